/* spmm_testdata.txt */
# Command then arguments, decimal except U address in hex
# T name | W idx wgt | C idx wgt | E col len node flag err | P sum node flag err
# H rows | S entries results busy | U addr write
T reset_state
S 0 0 0
T weight_rw
W 0 5
W 1 -3
W 2 127
W 3 -128
W 4 100
W 5 -100
W 10 7
W 63 42
C 0 5
C 1 -3
C 2 127
C 3 -128
C 63 42
T single_entry
E 0 1 3 1 0
P 5 3 1 0
E 1 1 200 0 0
P -3 200 0 0
E 3 1 17 1 0
P -128 17 1 0
T multi_entry
E 2 3 9 0 0
E 2 3 9 0 0
E 2 3 9 0 0
E 3 4 12 1 0
E 3 4 12 1 0
E 5 4 12 1 0
E 1 4 12 1 0
E 4 4 1 0 0
E 5 4 1 0 0
E 63 4 1 0 0
E 10 4 1 0 0
H 3
P 381 9 0 0
P -359 12 1 0
P 49 1 0 0
T back_pressure
E 0 1 1 0 0
E 1 1 2 1 0
E 2 1 3 0 0
E 3 1 4 1 0
E 4 1 5 0 0
E 5 1 6 1 0
H 4
S 2 4 0
P 5 1 0 0
P -3 2 1 0
P 127 3 0 0
P -128 4 1 0
P 100 5 0 0
P -100 6 1 0
T empty_pop
P 0 0 0 1
T zero_len
E 4 0 9 1 1
S 0 0 0
T unmapped
U 010 0
U 00C 1
U 102 0
U 200 1
C 0 5
T entry_full
E 63 1 20 0 0
E 63 1 21 1 0
E 63 1 22 0 0
E 63 1 23 1 0
H 4
E 0 4 30 1 0
E 1 4 30 1 0
E 2 4 30 1 0
E 3 4 30 1 0
E 10 4 31 0 0
E 10 4 31 0 0
E 63 4 31 0 0
E 5 4 31 0 0
S 8 4 0
E 0 1 0 0 1
P 42 20 0 0
P 42 21 1 0
P 42 22 0 0
P 42 23 1 0
P 1 30 1 0
P -44 31 0 0
S 0 0 0

/* src.f */
spmm_pkg.sv
sync_fifo.sv
weight_ram.sv
sparse_pe.sv
spmm_ctrl.sv
spmm_top.sv
spmm_assertions.sv
tb_spmm.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_spmm -o sim_spmm

./obj_dir/sim_spmm | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  exit 0
fi
exit 1

/* tb_spmm.sv */
`timescale 1ns/1ps

module tb_spmm;

  import spmm_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int WAIT_LIMIT = 200;

  logic              clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;

  logic [31:0] rng_state = 32'd36326;
  int unsigned cycle_cnt = 0;
  string       cur_test = "";
  int          test_errs = 0;
  int          total_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic        aborted = 1'b0;

  spmm_top #(
    .ENTRY_DEPTH  (8),
    .RESULT_DEPTH (4)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  bind spmm_top spmm_assertions assertions_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_vld_i (issue_vld),
    .res_vld_i   (res_vld),
    .res_full_i  (res_full),
    .pe_busy_i   (pe_busy)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_err(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %0b actual %0b", cur_test, what, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic check_weight(input string what, input weight_t exp, input weight_t act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic check_result(input string what, input result_t exp, input result_t act);
    if (act !== exp) begin
      $display("** Error %s: %s expected sum %0d node %0d flag %0b actual sum %0d node %0d flag %0b",
               cur_test, what, $signed(exp.sum), exp.num_node, exp.src_flag,
               $signed(act.sum), act.num_node, act.src_flag);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic check_status(input string what, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("** Error %s: %s expected ent %0d res %0d busy %0b actual ent %0d res %0d busy %0b",
               cur_test, what, exp.entry_count, exp.result_count, exp.pe_busy,
               act.entry_count, act.result_count, act.pe_busy);
      test_errs++;
      total_errs++;
    end
  endtask

  // One transfer, setup and access phase, random idle gap in front
  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    int   gap;
    logic rdy;
    rng_state = xorshift32(rng_state);
    gap = int'(rng_state[1:0]);
    @(negedge clk);
    repeat (gap) @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Sampled halfway to the access edge
    #(CLK_PERIOD / 4);
    rdata = prdata;
    err   = pslverr;
    rdy   = pready;
    // Zero wait states, so the first access cycle must complete
    check_err($sformatf("pready at %h", addr), 1'b1, rdy);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_status(output status_t st);
    logic [APB_DW-1:0] rdata;
    logic              err;
    apb_xfer(1'b0, STATUS_ADDR, '0, rdata, err);
    check_err("status read pslverr", 1'b0, err);
    st = status_t'(rdata[$bits(status_t)-1:0]);
  endtask

  task automatic wait_results(input int rows);
    status_t     st;
    int unsigned start;
    start = cycle_cnt;
    read_status(st);
    while (int'(st.result_count) < rows && !aborted) begin
      if (cycle_cnt - start > WAIT_LIMIT) begin
        $display("Timeout in %s: %0d results not queued within %0d cycles",
                 cur_test, rows, WAIT_LIMIT);
        test_errs++;
        total_errs++;
        aborted = 1'b1;
      end else begin
        read_status(st);
      end
    end
  endtask

  task automatic write_weight(input int idx, input int val);
    logic [APB_DW-1:0] wdata;
    logic [APB_DW-1:0] rdata;
    logic              err;
    wdata = '0;
    wdata[WGT_W-1:0] = WGT_W'(val);
    apb_xfer(1'b1, WEIGHT_BASE + APB_AW'(4 * idx), wdata, rdata, err);
    check_err("weight write pslverr", 1'b0, err);
  endtask

  task automatic read_back_weight(input int idx, input int val);
    logic [APB_DW-1:0] rdata;
    logic              err;
    weight_t           exp_w;
    exp_w = WGT_W'(val);
    apb_xfer(1'b0, WEIGHT_BASE + APB_AW'(4 * idx), '0, rdata, err);
    check_err("weight read pslverr", 1'b0, err);
    check_weight($sformatf("weight %0d", idx), exp_w, weight_t'(rdata[WGT_W-1:0]));
  endtask

  task automatic push_entry(input int col, input int len, input int node, input int flag,
                            input logic exp_err);
    entry_t            ent;
    status_t           st_before;
    status_t           st_after;
    logic [APB_DW-1:0] rdata;
    logic              err;
    ent.col_idx  = COL_W'(col);
    ent.row_len  = ROW_LEN_W'(len);
    ent.num_node = NODE_W'(node);
    ent.src_flag = flag[0];
    if (exp_err) begin
      read_status(st_before);
    end
    apb_xfer(1'b1, ENTRY_ADDR, {{(APB_DW - ENTRY_W){1'b0}}, ent}, rdata, err);
    check_err("entry push pslverr", exp_err, err);
    if (exp_err) begin
      read_status(st_after);
      check_status("status after rejected push", st_before, st_after);
    end
  endtask

  task automatic pop_result(input int sum, input int node, input int flag, input logic exp_err);
    result_t           exp_res;
    status_t           st_before;
    status_t           st_after;
    logic [APB_DW-1:0] rdata;
    logic              err;
    if (exp_err) begin
      read_status(st_before);
    end else begin
      wait_results(1);
    end
    if (!aborted) begin
      apb_xfer(1'b0, RESULT_ADDR, '0, rdata, err);
      check_err("result pop pslverr", exp_err, err);
      if (exp_err) begin
        read_status(st_after);
        check_status("status after rejected pop", st_before, st_after);
      end else begin
        exp_res.sum      = SUM_W'(sum);
        exp_res.num_node = NODE_W'(node);
        exp_res.src_flag = flag[0];
        check_result("result pop", exp_res, result_t'(rdata[$bits(result_t)-1:0]));
      end
    end
  endtask

  task automatic access_unmapped(input logic [APB_AW-1:0] addr, input logic wr);
    status_t           st_before;
    status_t           st_after;
    logic [APB_DW-1:0] rdata;
    logic              err;
    read_status(st_before);
    apb_xfer(wr, addr, 32'h0000_0011, rdata, err);
    check_err($sformatf("pslverr at %h", addr), 1'b1, err);
    read_status(st_after);
    check_status("status after unmapped access", st_before, st_after);
  endtask

  task automatic verify_status(input int ents, input int res, input int busy);
    status_t exp_st;
    status_t st;
    exp_st.entry_count  = CNT_W'(ents);
    exp_st.result_count = CNT_W'(res);
    exp_st.pe_busy      = busy[0];
    read_status(st);
    check_status("status", exp_st, st);
  endtask

  task automatic end_test();
    if (cur_test != "") begin
      tests_run++;
      if (test_errs == 0) begin
        $display("Test %s: ok", cur_test);
      end else begin
        $display("Test %s: %0d errors", cur_test, test_errs);
        tests_failed++;
      end
    end
    test_errs = 0;
  endtask

  initial begin : run_tests
    int    fd;
    int    n;
    int    f [5];
    string line;
    string args;
    byte   cmd;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("spmm_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file spmm_testdata.txt");
      total_errs++;
      aborted = 1'b1;
    end
    while (!aborted && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Strip line end and trailing blanks
      while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0A ||
             line.getc(line.len() - 1) == 8'h0D || line.getc(line.len() - 1) == 8'h20)) begin
        line = line.substr(0, line.len() - 2);
      end
      if (line.len() > 0 && line.getc(0) != 8'h23) begin
        cmd  = line.getc(0);
        args = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
        case (cmd)
          "T": begin
            end_test();
            cur_test = args;
          end
          "W": begin
            n = $sscanf(args, "%d %d", f[0], f[1]);
            write_weight(f[0], f[1]);
          end
          "C": begin
            n = $sscanf(args, "%d %d", f[0], f[1]);
            read_back_weight(f[0], f[1]);
          end
          "E": begin
            n = $sscanf(args, "%d %d %d %d %d", f[0], f[1], f[2], f[3], f[4]);
            push_entry(f[0], f[1], f[2], f[3], f[4][0]);
          end
          "P": begin
            n = $sscanf(args, "%d %d %d %d", f[0], f[1], f[2], f[3]);
            pop_result(f[0], f[1], f[2], f[3][0]);
          end
          "H": begin
            n = $sscanf(args, "%d", f[0]);
            wait_results(f[0]);
          end
          "S": begin
            n = $sscanf(args, "%d %d %d", f[0], f[1], f[2]);
            verify_status(f[0], f[1], f[2]);
          end
          "U": begin
            n = $sscanf(args, "%h %d", f[0], f[1]);
            access_unmapped(APB_AW'(f[0]), f[1][0]);
          end
          default: begin
            $display("Unknown command in stimulus file: %s", line);
            test_errs++;
            total_errs++;
          end
        endcase
      end
    end
    end_test();
    if (fd != 0) begin
      $fclose(fd);
    end

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0 && !aborted) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* spmm_assertions.sv */
`timescale 1ns/1ps

module spmm_assertions (
  input logic clk,
  input logic rst_n,
  input logic issue_vld_i,
  input logic res_vld_i,
  input logic res_full_i,
  input logic pe_busy_i
);

  // Issue margin keeps a slot free for every result
  result_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    res_vld_i |-> !res_full_i)
    else $error("result pushed into full result queue");

  // Row result trails the issue of its last entry by two cycles
  pe_latency: assert property (@(posedge clk) disable iff (!rst_n)
    res_vld_i |-> $past(issue_vld_i, 2))
    else $error("result without an issue two cycles earlier");

  pe_busy_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
    issue_vld_i |=> pe_busy_i)
    else $error("processing element not busy after an issue");

endmodule

/* spmm_top.sv */
`timescale 1ns/1ps

module spmm_top #(
  parameter int ENTRY_DEPTH  = 8,
  parameter int RESULT_DEPTH = 4
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [spmm_pkg::APB_AW-1:0] paddr_i,
  input  logic [spmm_pkg::APB_DW-1:0] pwdata_i,
  output logic [spmm_pkg::APB_DW-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o
);

  import spmm_pkg::*;

  localparam int ECNT_W = $clog2(ENTRY_DEPTH + 1);
  localparam int RCNT_W = $clog2(RESULT_DEPTH + 1);

  // Entry queue
  logic              ent_push;
  entry_t            ent_wdata;
  logic              ent_full;
  logic              ent_empty;
  logic [ECNT_W-1:0] ent_count;
  logic              ent_pop;
  entry_t            ent_head;
  // Result queue
  logic              res_vld;
  result_t           res_data;
  logic              res_full;
  logic              res_empty;
  logic [RCNT_W-1:0] res_count;
  logic              res_pop;
  result_t           res_head;
  // Weight memory
  logic              wgt_we;
  logic [COL_W-1:0]  wgt_addr;
  weight_t           wgt_wdata;
  weight_t           wgt_apb_rdata;
  logic [COL_W-1:0]  pe_wgt_addr;
  weight_t           pe_wgt;
  // Processing element
  logic              issue_vld;
  entry_t            issue_entry;
  logic              pe_busy;

  spmm_ctrl #(
    .ENTRY_DEPTH  (ENTRY_DEPTH),
    .RESULT_DEPTH (RESULT_DEPTH)
  ) ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .ent_push_o    (ent_push),
    .ent_wdata_o   (ent_wdata),
    .ent_full_i    (ent_full),
    .ent_empty_i   (ent_empty),
    .ent_count_i   (ent_count),
    .ent_pop_o     (ent_pop),
    .ent_head_i    (ent_head),
    .res_full_i    (res_full),
    .res_empty_i   (res_empty),
    .res_count_i   (res_count),
    .res_pop_o     (res_pop),
    .res_head_i    (res_head),
    .wgt_we_o      (wgt_we),
    .wgt_waddr_o   (wgt_addr),
    .wgt_wdata_o   (wgt_wdata),
    .wgt_rdata_i   (wgt_apb_rdata),
    .issue_vld_o   (issue_vld),
    .issue_entry_o (issue_entry),
    .pe_busy_i     (pe_busy)
  );

  sync_fifo #(
    .T     (entry_t),
    .DEPTH (ENTRY_DEPTH)
  ) entry_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (ent_push),
    .wdata_i (ent_wdata),
    .pop_i   (ent_pop),
    .rdata_o (ent_head),
    .full_o  (ent_full),
    .empty_o (ent_empty),
    .count_o (ent_count)
  );

  sync_fifo #(
    .T     (result_t),
    .DEPTH (RESULT_DEPTH)
  ) result_q (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (res_vld),
    .wdata_i (res_data),
    .pop_i   (res_pop),
    .rdata_o (res_head),
    .full_o  (res_full),
    .empty_o (res_empty),
    .count_o (res_count)
  );

  // APB address serves both the write port and the readback port
  weight_ram wram_i (
    .clk         (clk),
    .we_i        (wgt_we),
    .waddr_i     (wgt_addr),
    .wdata_i     (wgt_wdata),
    .raddr_i     (pe_wgt_addr),
    .rdata_o     (pe_wgt),
    .apb_raddr_i (wgt_addr),
    .apb_rdata_o (wgt_apb_rdata)
  );

  sparse_pe pe_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_vld_i   (issue_vld),
    .issue_entry_i (issue_entry),
    .wgt_addr_o    (pe_wgt_addr),
    .wgt_i         (pe_wgt),
    .res_vld_o     (res_vld),
    .res_o         (res_data),
    .busy_o        (pe_busy)
  );

endmodule

/* spmm_ctrl.sv */
`timescale 1ns/1ps

module spmm_ctrl #(
  parameter int  ENTRY_DEPTH  = 8,
  parameter int  RESULT_DEPTH = 4,
  localparam int ECNT_W       = $clog2(ENTRY_DEPTH + 1),
  localparam int RCNT_W       = $clog2(RESULT_DEPTH + 1)
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // APB slave
  input  logic                        psel_i,
  input  logic                        penable_i,
  input  logic                        pwrite_i,
  input  logic [spmm_pkg::APB_AW-1:0] paddr_i,
  input  logic [spmm_pkg::APB_DW-1:0] pwdata_i,
  output logic [spmm_pkg::APB_DW-1:0] prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  // Entry queue
  output logic                        ent_push_o,
  output spmm_pkg::entry_t            ent_wdata_o,
  input  logic                        ent_full_i,
  input  logic                        ent_empty_i,
  input  logic [ECNT_W-1:0]           ent_count_i,
  output logic                        ent_pop_o,
  input  spmm_pkg::entry_t            ent_head_i,
  // Result queue
  input  logic                        res_full_i,
  input  logic                        res_empty_i,
  input  logic [RCNT_W-1:0]           res_count_i,
  output logic                        res_pop_o,
  input  spmm_pkg::result_t           res_head_i,
  // Weight memory
  output logic                        wgt_we_o,
  output logic [spmm_pkg::COL_W-1:0]  wgt_waddr_o,
  output spmm_pkg::weight_t           wgt_wdata_o,
  input  spmm_pkg::weight_t           wgt_rdata_i,
  // Processing element
  output logic                        issue_vld_o,
  output spmm_pkg::entry_t            issue_entry_o,
  input  logic                        pe_busy_i
);

  import spmm_pkg::*;

  logic                 access;
  logic                 wr_acc;
  logic                 rd_acc;
  logic                 sel_entry;
  logic                 sel_result;
  logic                 sel_status;
  logic                 sel_weight;
  logic                 err;
  entry_t               wr_entry;
  status_t              status;
  logic [ROW_LEN_W-1:0] iss_pos_q;
  logic                 row_open;
  logic                 room;
  logic                 issue;
  logic                 issue_last;
  logic [1:0]           last_dly_q;
  logic [RCNT_W-1:0]    in_flight_q;
  logic [RCNT_W:0]      res_used;

  assign access = psel_i & penable_i;
  assign wr_acc = access & pwrite_i;
  assign rd_acc = access & ~pwrite_i;

  assign sel_entry  = paddr_i == ENTRY_ADDR;
  assign sel_result = paddr_i == RESULT_ADDR;
  assign sel_status = paddr_i == STATUS_ADDR;
  assign sel_weight = (paddr_i[APB_AW-1:COL_W+2] == WEIGHT_BASE[APB_AW-1:COL_W+2]) &&
                      (paddr_i[1:0] == 2'b00);

  assign wr_entry = entry_t'(pwdata_i[ENTRY_W-1:0]);

  // Wrong direction on a register decodes like an unmapped address
  always_comb begin
    err = 1'b0;
    if (sel_entry) begin
      err = ~pwrite_i | ent_full_i | (wr_entry.row_len == '0);
    end else if (sel_result) begin
      err = pwrite_i | res_empty_i;
    end else if (sel_status) begin
      err = pwrite_i;
    end else if (!sel_weight) begin
      err = 1'b1;
    end
  end

  assign pready_o    = 1'b1;
  assign pslverr_o   = access & err;
  assign ent_push_o  = wr_acc & sel_entry & ~err;
  assign ent_wdata_o = wr_entry;
  assign res_pop_o   = rd_acc & sel_result & ~err;
  assign wgt_we_o    = wr_acc & sel_weight;
  // Same index feeds the write port and the APB read port
  assign wgt_waddr_o = paddr_i[COL_W+1:2];
  assign wgt_wdata_o = pwdata_i[WGT_W-1:0];

  always_comb begin
    status.entry_count  = CNT_W'(ent_count_i);
    status.result_count = CNT_W'(res_count_i);
    status.pe_busy      = pe_busy_i;
    prdata_o = '0;
    if (rd_acc && !err) begin
      if (sel_status) begin
        prdata_o = APB_DW'(status);
      end else if (sel_result) begin
        prdata_o = APB_DW'(res_head_i);
      end else if (sel_weight) begin
        prdata_o = {{(APB_DW - WGT_W){1'b0}}, wgt_rdata_i};
      end
    end
  end

  // A new row starts only with a result slot reserved for it
  assign row_open   = iss_pos_q != '0;
  assign res_used   = {1'b0, res_count_i} + {1'b0, in_flight_q};
  assign room       = ~res_full_i & (res_used < RESULT_DEPTH);
  assign issue      = ~ent_empty_i & (row_open | room);
  assign issue_last = iss_pos_q == ent_head_i.row_len - 1'b1;

  assign ent_pop_o     = issue;
  assign issue_vld_o   = issue;
  assign issue_entry_o = ent_head_i;

  // Result push trails the last issue by two cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss_pos_q   <= '0;
      last_dly_q  <= '0;
      in_flight_q <= '0;
    end else begin
      if (issue) begin
        iss_pos_q <= issue_last ? '0 : iss_pos_q + 1'b1;
      end
      last_dly_q <= {last_dly_q[0], issue & issue_last};
      case ({issue & ~row_open, last_dly_q[1]})
        2'b10:   in_flight_q <= in_flight_q + 1'b1;
        2'b01:   in_flight_q <= in_flight_q - 1'b1;
        default: in_flight_q <= in_flight_q;
      endcase
    end
  end

endmodule

/* sparse_pe.sv */
`timescale 1ns/1ps

module sparse_pe (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       issue_vld_i,
  input  spmm_pkg::entry_t           issue_entry_i,
  output logic [spmm_pkg::COL_W-1:0] wgt_addr_o,
  input  spmm_pkg::weight_t          wgt_i,
  output logic                       res_vld_o,
  output spmm_pkg::result_t          res_o,
  output logic                       busy_o
);

  import spmm_pkg::*;

  logic [ROW_LEN_W-1:0] pos_q;
  logic                 first;
  logic                 last;
  // Stage 1, waiting for the weight
  logic                 s1_vld_q;
  logic                 s1_first_q;
  logic                 s1_last_q;
  logic [NODE_W-1:0]    s1_node_q;
  logic                 s1_flag_q;
  // Stage 2, accumulated row
  sum_t                 sum_q;
  sum_t                 wgt_ext;
  logic                 res_vld_q;
  logic [NODE_W-1:0]    res_node_q;
  logic                 res_flag_q;

  // Weight address goes out in the issue cycle
  assign wgt_addr_o = issue_entry_i.col_idx;

  assign first   = pos_q == '0;
  assign last    = pos_q == issue_entry_i.row_len - 1'b1;
  assign wgt_ext = wgt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_q      <= '0;
      s1_vld_q   <= 1'b0;
      s1_first_q <= 1'b0;
      s1_last_q  <= 1'b0;
      res_vld_q  <= 1'b0;
    end else begin
      if (issue_vld_i) begin
        pos_q <= last ? '0 : pos_q + 1'b1;
      end
      s1_vld_q   <= issue_vld_i;
      s1_first_q <= issue_vld_i & first;
      s1_last_q  <= issue_vld_i & last;
      res_vld_q  <= s1_vld_q & s1_last_q;
    end
  end

  // Metadata follows the entry, latched with the row's last weight
  always_ff @(posedge clk) begin
    s1_node_q <= issue_entry_i.num_node;
    s1_flag_q <= issue_entry_i.src_flag;
    if (s1_vld_q) begin
      sum_q <= s1_first_q ? wgt_ext : sum_q + wgt_ext;
    end
    if (s1_vld_q && s1_last_q) begin
      res_node_q <= s1_node_q;
      res_flag_q <= s1_flag_q;
    end
  end

  always_comb begin
    res_o.sum      = sum_q;
    res_o.num_node = res_node_q;
    res_o.src_flag = res_flag_q;
  end

  assign res_vld_o = res_vld_q;
  // Also busy while a row is only partly issued
  assign busy_o    = s1_vld_q | res_vld_q | (pos_q != '0);

endmodule

/* weight_ram.sv */
`timescale 1ns/1ps

module weight_ram (
  input  logic                       clk,
  input  logic                       we_i,
  input  logic [spmm_pkg::COL_W-1:0] waddr_i,
  input  spmm_pkg::weight_t          wdata_i,
  input  logic [spmm_pkg::COL_W-1:0] raddr_i,
  output spmm_pkg::weight_t          rdata_o,
  input  logic [spmm_pkg::COL_W-1:0] apb_raddr_i,
  output spmm_pkg::weight_t          apb_rdata_o
);

  import spmm_pkg::*;

  weight_t mem [NUM_WGT];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Both read ports have one cycle of latency
  always_ff @(posedge clk) begin
    rdata_o     <= mem[raddr_i];
    apb_rdata_o <= mem[apb_raddr_i];
  end

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4,
  localparam int AW    = $clog2(DEPTH),
  localparam int CW    = $clog2(DEPTH + 1)
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          push_i,
  input  T              wdata_i,
  input  logic          pop_i,
  output T              rdata_o,
  output logic          full_o,
  output logic          empty_o,
  output logic [CW-1:0] count_o
);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign full_o  = count_q == CW'(DEPTH);
  assign empty_o = count_q == '0;
  assign count_o = count_q;
  // Head is visible without a read cycle
  assign rdata_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* spmm_pkg.sv */
package spmm_pkg;

  // Field widths, fixed because they shape the APB register layout
  localparam int COL_W     = 6;
  localparam int ROW_LEN_W = 4;
  localparam int NODE_W    = 8;
  localparam int WGT_W     = 8;
  localparam int SUM_W     = 12;
  localparam int CNT_W     = 4;
  localparam int NUM_WGT   = 1 << COL_W;

  // APB bus widths
  localparam int APB_AW = 12;
  localparam int APB_DW = 32;

  typedef logic signed [WGT_W-1:0] weight_t;
  typedef logic signed [SUM_W-1:0] sum_t;

  // One nonzero of a sparse row, row info repeated in every entry
  typedef struct packed {
    logic [COL_W-1:0]     col_idx;
    logic [ROW_LEN_W-1:0] row_len;
    logic [NODE_W-1:0]    num_node;
    logic                 src_flag;
  } entry_t;

  typedef struct packed {
    sum_t              sum;
    logic [NODE_W-1:0] num_node;
    logic              src_flag;
  } result_t;

  typedef struct packed {
    logic [CNT_W-1:0] entry_count;
    logic [CNT_W-1:0] result_count;
    logic             pe_busy;
  } status_t;

  localparam int ENTRY_W = $bits(entry_t);

  // Register map
  localparam logic [APB_AW-1:0] ENTRY_ADDR  = 12'h004;
  localparam logic [APB_AW-1:0] RESULT_ADDR = 12'h008;
  localparam logic [APB_AW-1:0] STATUS_ADDR = 12'h00C;
  localparam logic [APB_AW-1:0] WEIGHT_BASE = 12'h100;

endpackage
